/* all.f */
design/z80DecodePkg.sv
design/opBusIf.sv
design/opcodeClassifier.sv
design/microOpQueue.sv
design/controlSequencer.sv
design/z80Decoder.sv
testbench/z80DecoderTb.sv

/* design/controlSequencer.sv */
// Control sequencer that fetches micro-operations and issues one control step per cycle
`default_nettype none

module controlSequencer (
    input  logic                  clk,
    input  logic                  reset,
    opBusIf.master                popBus,
    output logic                  stepValid,
    output logic                  regRead,
    output logic                  memRead,
    output logic                  regWrite,
    output logic                  memWrite,
    output logic                  aluExec,
    output logic                  accWrite,
    output logic                  halted,
    output z80DecodePkg::regCodeT readSel,
    output z80DecodePkg::regCodeT writeSel,
    output z80DecodePkg::aluOpT   aluOp
);

    import z80DecodePkg::*;

    typedef enum logic [1:0] {fetch, readStep, finalStep, stopped} seqStateT;

    seqStateT state;
    microOpT  curOp;
    logic     popCyc;

    assign popBus.cyc     = popCyc;
    assign popBus.stb     = popCyc;
    assign popBus.we      = 1'b0;
    assign popBus.writeOp = '0;               // Read-only master

    // ##############################
    // Fetch and step FSM
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= fetch;
            popCyc <= 1'b0;
        end else begin
            case (state)
                fetch: begin
                    if (popBus.ack) begin
                        popCyc <= 1'b0;
                        // HALT has no read step
                        state  <= (popBus.readOp.kind == kindHalt) ? finalStep : readStep;
                    end else begin
                        popCyc <= 1'b1;
                    end
                end
                readStep: state <= finalStep;
                finalStep: begin
                    if (curOp.kind == kindHalt) begin
                        state <= stopped;
                    end else begin
                        state  <= fetch;
                        popCyc <= 1'b1;
                    end
                end
                stopped: state <= stopped;    // Left only through reset
                default: state <= fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch && popBus.ack) begin
            curOp <= popBus.readOp;
        end
    end

    // ##############################
    // Step outputs
    // ##############################

    always_comb begin
        stepValid = 1'b0;
        regRead   = 1'b0;
        memRead   = 1'b0;
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        aluExec   = 1'b0;
        accWrite  = 1'b0;
        halted    = (state == stopped);
        readSel   = regB;
        writeSel  = regB;
        aluOp     = aluAdd;
        case (state)
            readStep: begin
                stepValid = 1'b1;
                readSel   = curOp.src;
                if (curOp.src == memHl) begin
                    memRead = 1'b1;
                end else begin
                    regRead = 1'b1;
                end
            end
            finalStep: begin
                stepValid = 1'b1;
                case (curOp.kind)
                    kindMove: begin
                        writeSel = curOp.dst;
                        if (curOp.dst == memHl) begin
                            memWrite = 1'b1;
                        end else begin
                            regWrite = 1'b1;
                        end
                    end
                    kindAlu: begin
                        aluExec  = 1'b1;
                        aluOp    = curOp.alu;
                        accWrite = (curOp.alu != aluCp);  // CP only sets flags
                    end
                    default: halted = 1'b1;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/microOpQueue.sv */
// Micro-operation FIFO with a Wishbone slave port on each side
`default_nettype none

module microOpQueue #(
    parameter int queueDepth = 4
) (
    input  logic  clk,
    input  logic  reset,
    opBusIf.slave pushBus,
    opBusIf.slave popBus
);

    import z80DecodePkg::*;

    localparam int ptrWidth   = $clog2(queueDepth);
    localparam int countWidth = $clog2(queueDepth + 1);

    microOpT               entries [queueDepth];
    microOpT               headOp;
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [countWidth-1:0] count;
    logic                  full;
    logic                  empty;
    logic                  doPush;
    logic                  doPop;
    logic                  pushAck;
    logic                  popAck;

    assign full  = (count == countWidth'(queueDepth));
    assign empty = (count == '0);

    // ##############################
    // Handshake
    // ##############################

    // Ack of the previous cycle blocks a repeat of the same transfer
    assign doPush = pushBus.cyc && pushBus.stb && pushBus.we && !pushAck && !full;
    assign doPop  = popBus.cyc && popBus.stb && !popBus.we && !popAck && !empty;

    assign pushBus.ack    = pushAck;
    assign pushBus.readOp = '0;               // Write-only port
    assign popBus.ack     = popAck;
    assign popBus.readOp  = headOp;

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            pushAck <= 1'b0;
            popAck  <= 1'b0;
        end else begin
            pushAck <= doPush;
            popAck  <= doPop;
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;        // Wraps, depth is a power of two
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ##############################
    // Storage
    // ##############################

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= pushBus.writeOp;
        end
        if (doPop) begin
            headOp <= entries[rdPtr];         // Presented in the ack cycle
        end
    end

endmodule

`default_nettype wire

/* design/opBusIf.sv */
// Wishbone classic link that moves micro-operations between decoder blocks
`default_nettype none

interface opBusIf;

    import z80DecodePkg::*;

    logic    cyc;
    logic    stb;
    logic    we;
    logic    ack;
    microOpT writeOp;                         // Master to slave when we is high
    microOpT readOp;                          // Slave to master in the ack cycle

    modport master (
        output cyc, stb, we, writeOp,
        input  ack, readOp
    );

    modport slave (
        input  cyc, stb, we, writeOp,
        output ack, readOp
    );

endinterface

`default_nettype wire

/* design/opcodeClassifier.sv */
// Opcode classifier that turns Z80 first bytes into micro-operations for the queue
`default_nettype none

module opcodeClassifier (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [z80DecodePkg::byteWidth-1:0]  opcode,
    output logic                                ack,
    opBusIf.master                              pushBus
);

    import z80DecodePkg::*;

    localparam logic [byteWidth-1:0] haltOpcode = 8'h76;

    typedef enum logic {idle, pushing} pushStateT;

    pushStateT state;
    microOpT   decodedOp;
    microOpT   heldOp;
    logic      request;
    logic      keep;

    assign request = cyc && stb && !ack;      // No second accept while acking

    // ##############################
    // Byte classification
    // ##############################

    always_comb begin
        decodedOp.kind = kindMove;
        decodedOp.src  = regCodeT'(opcode[2:0]);
        decodedOp.dst  = regCodeT'(opcode[5:3]);
        decodedOp.alu  = aluOpT'(opcode[5:3]);  // Don't care for moves
        keep           = 1'b0;
        if (we) begin
            if (opcode == haltOpcode) begin
                decodedOp.kind = kindHalt;
                keep           = 1'b1;
            end else if (opcode[7:6] == 2'b01) begin
                keep = 1'b1;
            end else if (opcode[7:6] == 2'b10) begin
                decodedOp.kind = kindAlu;
                decodedOp.dst  = regA;
                keep           = 1'b1;
            end
        end
    end

    // ##############################
    // Push sequencing
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            ack   <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                idle: begin
                    if (request) begin
                        if (keep) begin
                            state <= pushing;
                        end else begin
                            ack <= 1'b1;    // Groups 00 and 11 are dropped here
                        end
                    end
                end
                pushing: begin
                    if (pushBus.ack) begin
                        state <= idle;
                        ack   <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && request && keep) begin
            heldOp <= decodedOp;
        end
    end

    assign pushBus.cyc     = (state == pushing);
    assign pushBus.stb     = (state == pushing);
    assign pushBus.we      = 1'b1;
    assign pushBus.writeOp = heldOp;

endmodule

`default_nettype wire

/* design/z80DecodePkg.sv */
// Z80 decoder types shared by the classifier, the micro-op queue and the sequencer
`default_nettype none

package z80DecodePkg;

    localparam int byteWidth = 8;             // One opcode byte

    // ##############################
    // Operand and ALU fields
    // ##############################

    // Bits 2..0 or 5..3 of a group 01/10 opcode
    typedef enum logic [2:0] {
        regB,
        regC,
        regD,
        regE,
        regH,
        regL,
        memHl,                                // (HL) memory operand
        regA
    } regCodeT;

    // Bits 5..3 of a group 10 opcode
    typedef enum logic [2:0] {
        aluAdd,
        aluAdc,
        aluSub,
        aluSbc,
        aluAnd,
        aluXor,
        aluOr,
        aluCp                                 // Compare, result discarded
    } aluOpT;

    // ##############################
    // Micro-operation
    // ##############################

    typedef enum logic [1:0] {
        kindMove,
        kindAlu,
        kindHalt
    } opKindT;

    typedef struct packed {
        opKindT  kind;
        regCodeT src;
        regCodeT dst;                         // Accumulator for ALU ops
        aluOpT   alu;
    } microOpT;

endpackage

`default_nettype wire

/* design/z80Decoder.sv */
// Z80 opcode decoder top with a Wishbone classic slave input and control step outputs
`default_nettype none

module z80Decoder #(
    parameter int queueDepth = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [z80DecodePkg::byteWidth-1:0]  opcode,
    output logic                                ack,
    output logic                                stepValid,
    output logic                                regRead,
    output logic                                memRead,
    output logic                                regWrite,
    output logic                                memWrite,
    output logic                                aluExec,
    output logic                                accWrite,
    output logic                                halted,
    output z80DecodePkg::regCodeT               readSel,
    output z80DecodePkg::regCodeT               writeSel,
    output z80DecodePkg::aluOpT                 aluOp
);

    opBusIf pushBus ();                       // Classifier to queue
    opBusIf popBus ();                        // Queue to sequencer

    opcodeClassifier i_opcodeClassifier (
        .clk     (clk),
        .reset   (reset),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .opcode  (opcode),
        .ack     (ack),
        .pushBus (pushBus)
    );

    microOpQueue #(
        .queueDepth (queueDepth)
    ) i_microOpQueue (
        .clk     (clk),
        .reset   (reset),
        .pushBus (pushBus),
        .popBus  (popBus)
    );

    controlSequencer i_controlSequencer (
        .clk       (clk),
        .reset     (reset),
        .popBus    (popBus),
        .stepValid (stepValid),
        .regRead   (regRead),
        .memRead   (memRead),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .aluExec   (aluExec),
        .accWrite  (accWrite),
        .halted    (halted),
        .readSel   (readSel),
        .writeSel  (writeSel),
        .aluOp     (aluOp)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the Z80 decoder testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f all.f --top-module z80DecoderTb -o z80DecoderSim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/z80DecoderSim > sim.log 2>&1
simStatus=$?
if [ "$simStatus" -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
fi

if grep -q "^TESTS PASSED$" sim.log; then
    echo "Simulation passed, see sim.log"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* testbench/opcodeInput.txt */
// Columns: opcode _ kind _ read operand _ write operand or ALU operation
// Kind: 0 move, 1 ALU, 2 HALT, 3 dropped with no steps
41_0_1_0 // LD B,C
78_0_0_7 // LD A,B
00_3_0_0 // NOP
5A_0_2_3 // LD E,D
6C_0_4_5 // LD L,H
55_0_5_2 // LD D,L
4F_0_7_1 // LD C,A
C3_3_0_0 // JP nn
64_0_4_4 // LD H,H
7E_0_6_7 // LD A,(HL)
70_0_0_6 // LD (HL),B
80_1_0_0 // ADD A,B
89_1_1_1 // ADC A,C
3E_3_0_0 // LD A,n
92_1_2_2 // SUB D
9B_1_3_3 // SBC A,E
A4_1_4_4 // AND H
AD_1_5_5 // XOR L
FE_3_0_0 // CP n
B6_1_6_6 // OR (HL)
BF_1_7_7 // CP A
76_2_0_0 // HALT

/* testbench/z80DecoderTb.sv */
// Testbench for the Z80 opcode decoder that drives Wishbone writes and checks the control steps
`default_nettype none

module z80DecoderTb;

    import z80DecodePkg::*;

    localparam int          queueDepth = 4;
    localparam int          clkPeriod  = 8;
    localparam int          maxVectors = 64;
    localparam logic [19:0] emptySlot  = 20'hFFFFF;   // Kind code F never appears in the file
    localparam logic [3:0]  codeMove   = 4'd0;
    localparam logic [3:0]  codeHalt   = 4'd2;
    localparam logic [3:0]  codeDrop   = 4'd3;

    logic                 clk;
    logic                 reset;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [byteWidth-1:0] opcode;
    logic                 ack;
    logic                 stepValid;
    logic                 regRead;
    logic                 memRead;
    logic                 regWrite;
    logic                 memWrite;
    logic                 aluExec;
    logic                 accWrite;
    logic                 halted;
    regCodeT              readSel;
    regCodeT              writeSel;
    aluOpT                aluOp;

    logic [19:0]          vectors [maxVectors];    // Opcode, kind, read operand, write or ALU
    int                   lineCount;
    logic                 haltSeen;

    z80Decoder #(
        .queueDepth (queueDepth)
    ) i_z80Decoder (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .opcode    (opcode),
        .ack       (ack),
        .stepValid (stepValid),
        .regRead   (regRead),
        .memRead   (memRead),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .aluExec   (aluExec),
        .accWrite  (accWrite),
        .halted    (halted),
        .readSel   (readSel),
        .writeSel  (writeSel),
        .aluOp     (aluOp)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // ##############################
    // Compare tasks
    // ##############################

    task automatic abortRun();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %0b actual %0b", $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkReg(input string name, input regCodeT expected, input regCodeT actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %s actual %s", $time, name,
                     expected.name(), actual.name());
            abortRun();
        end
    endtask

    task automatic checkAluOp(input string name, input aluOpT expected, input aluOpT actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %s actual %s", $time, name,
                     expected.name(), actual.name());
            abortRun();
        end
    endtask

    task automatic expectIdleOutputs();
        checkBit("ack", 1'b0, ack);
        checkBit("stepValid", 1'b0, stepValid);
        checkBit("regRead", 1'b0, regRead);
        checkBit("memRead", 1'b0, memRead);
        checkBit("regWrite", 1'b0, regWrite);
        checkBit("memWrite", 1'b0, memWrite);
        checkBit("aluExec", 1'b0, aluExec);
        checkBit("accWrite", 1'b0, accWrite);
        checkBit("halted", 1'b0, halted);
        checkReg("readSel", regB, readSel);
        checkReg("writeSel", regB, writeSel);
        checkAluOp("aluOp", aluAdd, aluOp);
    endtask

    // ##############################
    // Wishbone driver
    // ##############################

    task automatic loadVectors();
        for (int i = 0; i < maxVectors; i++) begin
            vectors[i] = emptySlot;
        end
        $readmemh("testbench/opcodeInput.txt", vectors);
        while (lineCount < maxVectors && vectors[lineCount] !== emptySlot) begin
            lineCount++;
        end
        if (lineCount == 0) begin
            $display("No opcode lines could be read from testbench/opcodeInput.txt");
            abortRun();
        end
    endtask

    // A zero cycle limit waits for ack without bound
    task automatic writeByte(input logic [7:0] op, input int maxCycles, output logic acked);
        int waited;
        waited = 0;
        acked  = 1'b0;
        @(negedge clk);
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = 1'b1;
        opcode = op;
        while (!acked && (maxCycles == 0 || waited < maxCycles)) begin
            @(negedge clk);
            waited++;
            acked = (ack === 1'b1);
        end
        cyc = 1'b0;                                    // Released with or without ack
        stb = 1'b0;
    endtask

    task automatic driveAll();
        logic acked;
        for (int i = 0; i < lineCount; i++) begin
            repeat ($urandom % 3) @(negedge clk);    // Random idle gap
            writeByte(vectors[i][19:12], 0, acked);
        end
    endtask

    // ##############################
    // Step monitor
    // ##############################

    task automatic waitForStep();
        do begin
            @(negedge clk);
        end while (stepValid !== 1'b1);
    endtask

    task automatic verifyReadStep(input logic [19:0] vec);
        logic fromMem;
        fromMem = (vec[7:4] == 4'd6);
        checkReg("readSel", regCodeT'(vec[6:4]), readSel);
        checkBit("regRead", !fromMem, regRead);
        checkBit("memRead", fromMem, memRead);
        checkBit("regWrite", 1'b0, regWrite);
        checkBit("memWrite", 1'b0, memWrite);
        checkBit("aluExec", 1'b0, aluExec);
        checkBit("accWrite", 1'b0, accWrite);
        checkBit("halted", 1'b0, halted);
    endtask

    task automatic verifyFinalStep(input logic [19:0] vec);
        logic toMem;
        toMem = (vec[3:0] == 4'd6);
        checkBit("stepValid", 1'b1, stepValid);       // Final step follows directly
        checkBit("regRead", 1'b0, regRead);
        checkBit("memRead", 1'b0, memRead);
        checkBit("halted", 1'b0, halted);
        if (vec[11:8] == codeMove) begin
            checkReg("writeSel", regCodeT'(vec[2:0]), writeSel);
            checkBit("regWrite", !toMem, regWrite);
            checkBit("memWrite", toMem, memWrite);
            checkBit("aluExec", 1'b0, aluExec);
            checkBit("accWrite", 1'b0, accWrite);
        end else begin
            checkAluOp("aluOp", aluOpT'(vec[2:0]), aluOp);
            checkBit("aluExec", 1'b1, aluExec);
            checkBit("accWrite", vec[3:0] != 4'd7, accWrite);   // CP keeps A
            checkBit("regWrite", 1'b0, regWrite);
            checkBit("memWrite", 1'b0, memWrite);
        end
    endtask

    task automatic followSteps();
        for (int i = 0; i < lineCount; i++) begin
            if (vectors[i][11:8] == codeDrop) begin
                continue;                              // Dropped bytes give no steps
            end
            waitForStep();
            if (vectors[i][11:8] == codeHalt) begin
                checkBit("halted", 1'b1, halted);
                checkBit("regRead", 1'b0, regRead);
                checkBit("memRead", 1'b0, memRead);
                checkBit("regWrite", 1'b0, regWrite);
                checkBit("memWrite", 1'b0, memWrite);
                checkBit("aluExec", 1'b0, aluExec);
                checkBit("accWrite", 1'b0, accWrite);
                @(negedge clk);
                checkBit("halted", 1'b1, halted);
                haltSeen = 1'b1;
                break;
            end
            verifyReadStep(vectors[i]);
            @(negedge clk);
            verifyFinalStep(vectors[i]);
        end
    endtask

    always @(negedge clk) begin
        if (haltSeen) begin
            checkBit("halted", 1'b1, halted);
            checkBit("stepValid", 1'b0, stepValid);
        end
    end

    // Sequencer is stopped, so the queue fills and the next byte stalls
    task automatic checkBackPressure();
        logic acked;
        for (int i = 0; i < queueDepth; i++) begin
            writeByte(8'h41 + 8'(i), 20, acked);
            if (!acked) begin
                $display("A byte after HALT got no ack although the queue had room");
                abortRun();
            end
        end
        writeByte(8'h41 + 8'(queueDepth), 20, acked);
        if (acked) begin
            $display("A byte was acknowledged while the queue was full");
            abortRun();
        end
    endtask

    // ##############################
    // Watchdog and main sequence
    // ##############################

    initial begin
        wait (lineCount > 0);
        #(lineCount * 20 * clkPeriod + 200);
        $display("Watchdog expired with control steps still missing");
        abortRun();
    end

    initial begin
        reset     = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        opcode    = '0;
        lineCount = 0;
        haltSeen  = 1'b0;
        void'($urandom(39));
        loadVectors();
        repeat (5) begin
            @(negedge clk);
            expectIdleOutputs();
        end
        reset = 1'b0;
        @(negedge clk);
        expectIdleOutputs();
        fork
            driveAll();
            followSteps();
        join
        checkBackPressure();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
